//--- tb.f
hdl/dcache_pkg.sv
hdl/line_xfer_if.sv
hdl/cache_arrays.sv
hdl/miss_ctrl.sv
hdl/axi_burst_engine.sv
hdl/dcache_top.sv
test/dcache_checker.sv
test/tb_dcache.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - files:
      - hdl/dcache_pkg.sv
      - hdl/line_xfer_if.sv
      - hdl/cache_arrays.sv
      - hdl/miss_ctrl.sv
      - hdl/axi_burst_engine.sv
      - hdl/dcache_top.sv
  - target: test
    files:
      - test/dcache_checker.sv
      - test/tb_dcache.sv

//--- test/tb_dcache.sv
`timescale 1ns/1ns
`default_nettype none

module tb_dcache;

    localparam logic [31:0] init_key = 32'h3c5a_96e1;
    localparam int accept_timeout = 3000;
    localparam int drain_timeout = 3000;

    typedef struct packed {
        logic wr;
        logic [3:0] be;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp;
        logic fill;
        logic wb;
    } entry_t;

    logic clk = 1'b0;
    logic rst, req, wr;
    logic [3:0] be, wstrb;
    logic [31:0] addr, wdata, rdata, exp_rdata;
    logic data_ok, stall, exp_fill, exp_wb;
    logic [31:0] araddr, awaddr, wdata_m;
    logic [7:0] arlen, awlen;
    logic arvalid, rready, awvalid, wlast, wvalid;
    logic arready = 1'b0;
    logic awready = 1'b0;
    logic wready = 1'b0;
    logic rvalid = 1'b0;
    logic rlast = 1'b0;
    logic bvalid = 1'b0;
    logic [31:0] rdata_m = 32'h0;
    int value_errs, other_errs, pending;
    int timeouts = 0;

    entry_t tbl[$];
    logic [31:0] ref_mem [logic [31:0]];
    logic [31:0] mem [logic [31:0]];
    logic [31:0] lfsr = 32'hccfd_cf3d;
    logic [31:0] rd_base, wr_base;
    logic [3:0] rd_beat, wr_beat;
    logic rd_busy = 1'b0;

    dcache_top dut (.*);

    dcache_checker #(.init_key(init_key)) u_checker (.*);

    always #4 clk = ~clk;

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic rand_bit();
        logic b;
        b = lfsr[31];
        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        return b;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        if (mem.exists(a)) return mem[a];
        return a ^ init_key;
    endfunction

    function automatic logic [31:0] ref_word(input logic [31:0] a);
        if (ref_mem.exists(a)) return ref_mem[a];
        return a ^ init_key;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] lanes);
        logic [31:0] mask;
        mask = {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    task automatic add_access(input logic st, input logic [3:0] lanes, input logic [31:0] a,
                              input logic [31:0] d, input logic fill, input logic wb);
        entry_t e;
        if (st) ref_mem[a] = merge_bytes(ref_word(a), d, lanes);
        e.wr = st;
        e.be = lanes;
        e.addr = a;
        e.wdata = d;
        e.exp = st ? 32'h0 : ref_word(a);
        e.fill = fill;
        e.wb = wb;
        tbl.push_back(e);
    endtask

    task automatic build_table();
        // one line in set 1 and a store miss in set 2
        add_access(1'b0, 4'h0, 32'h0001_0024, 32'h0, 1'b1, 1'b0);
        add_access(1'b0, 4'h0, 32'h0001_003c, 32'h0, 1'b0, 1'b0);
        add_access(1'b1, 4'b0101, 32'h0001_0028, 32'h1122_3344, 1'b0, 1'b0);
        add_access(1'b0, 4'h0, 32'h0001_0028, 32'h0, 1'b0, 1'b0);
        add_access(1'b1, 4'b1100, 32'h0005_0044, 32'hdead_beef, 1'b1, 1'b0);
        add_access(1'b0, 4'h0, 32'h0005_0044, 32'h0, 1'b0, 1'b0);
        // lines A B C all map to set 5
        add_access(1'b0, 4'h0, 32'h0000_10a0, 32'h0, 1'b1, 1'b0);
        add_access(1'b0, 4'h0, 32'h0000_20a4, 32'h0, 1'b1, 1'b0);
        add_access(1'b0, 4'h0, 32'h0000_10a8, 32'h0, 1'b0, 1'b0);
        add_access(1'b0, 4'h0, 32'h0000_30ac, 32'h0, 1'b1, 1'b0);
        add_access(1'b0, 4'h0, 32'h0000_10b0, 32'h0, 1'b0, 1'b0);
        add_access(1'b0, 4'h0, 32'h0000_20b4, 32'h0, 1'b1, 1'b0);
        // dirty A becomes the victim of C
        add_access(1'b1, 4'hf, 32'h0000_10a4, 32'h0bad_f00d, 1'b0, 1'b0);
        add_access(1'b0, 4'h0, 32'h0000_20b8, 32'h0, 1'b0, 1'b0);
        add_access(1'b0, 4'h0, 32'h0000_30a0, 32'h0, 1'b1, 1'b1);
        add_access(1'b0, 4'h0, 32'h0000_10a4, 32'h0, 1'b1, 1'b0);
        // streaming hits
        add_access(1'b0, 4'h0, 32'h0001_0020, 32'h0, 1'b0, 1'b0);
        add_access(1'b0, 4'h0, 32'h0001_0024, 32'h0, 1'b0, 1'b0);
        add_access(1'b1, 4'b0010, 32'h0001_0030, 32'ha5a5_a5a5, 1'b0, 1'b0);
        add_access(1'b0, 4'h0, 32'h0001_0030, 32'h0, 1'b0, 1'b0);
        add_access(1'b0, 4'h0, 32'h0001_003c, 32'h0, 1'b0, 1'b0);
        add_access(1'b0, 4'h0, 32'h0001_0028, 32'h0, 1'b0, 1'b0);
    endtask

    // starts after a rising edge and returns at the accepting edge
    task automatic apply_entry(input int i);
        int waited;
        logic taken;
        req <= 1'b1;
        wr <= tbl[i].wr;
        be <= tbl[i].be;
        addr <= tbl[i].addr;
        wdata <= tbl[i].wdata;
        exp_rdata <= tbl[i].exp;
        exp_fill <= tbl[i].fill;
        exp_wb <= tbl[i].wb;
        waited = 0;
        taken = 1'b0;
        while (!taken && waited < accept_timeout) begin
            @(negedge clk);
            taken = !stall;
            @(posedge clk);
            waited++;
        end
        if (!taken) begin
            timeouts++;
            $display("timeout waiting for request %0d to be accepted", i);
        end
    endtask

    // memory model with random ready and valid gaps
    always @(posedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            awready <= 1'b0;
            wready <= 1'b0;
            rvalid <= 1'b0;
            rlast <= 1'b0;
            bvalid <= 1'b0;
            rd_busy <= 1'b0;
        end else begin
            arready <= rand_bit();
            awready <= rand_bit();
            wready <= rand_bit();
            bvalid <= 1'b0;
            if (arvalid && arready) begin
                rd_base <= araddr;
                rd_beat <= 4'd0;
                rd_busy <= 1'b1;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                rlast <= 1'b0;
                rd_beat <= rd_beat + 4'd1;
                if (rlast) rd_busy <= 1'b0;
            end else if (rd_busy && !rvalid && rand_bit()) begin
                rvalid <= 1'b1;
                rdata_m <= mem_word(rd_base + {rd_beat, 2'b00});
                rlast <= rd_beat == 4'd7;
            end
            if (awvalid && awready) begin
                wr_base <= awaddr;
                wr_beat <= 4'd0;
            end
            if (wvalid && wready) begin
                mem[wr_base + {wr_beat, 2'b00}] = wdata_m;
                wr_beat <= wr_beat + 4'd1;
                if (wlast) bvalid <= 1'b1;
            end
        end
    end

    initial begin
        int waited;
        rst = 1'b1;
        req = 1'b0;
        wr = 1'b0;
        be = 4'h0;
        addr = 32'h0;
        wdata = 32'h0;
        exp_rdata = 32'h0;
        exp_fill = 1'b0;
        exp_wb = 1'b0;
        build_table();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        foreach (tbl[i]) begin
            if (timeouts == 0) apply_entry(i);
        end
        req <= 1'b0;
        waited = 0;
        while (pending != 0 && waited < drain_timeout) begin
            @(posedge clk);
            waited++;
        end
        if (pending != 0) begin
            timeouts++;
            $display("timeout waiting for %0d requests to finish", pending);
        end
        repeat (2) @(posedge clk);
        $display("error counts: %0d value, %0d protocol, %0d timeout",
            value_errs, other_errs, timeouts);
        if (value_errs == 0 && other_errs == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/dcache_checker.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_checker #(
    parameter logic [31:0] init_key = 32'h0
) (
    input wire logic clk,
    input wire logic rst,
    input wire logic req,
    input wire logic wr,
    input wire logic [3:0] be,
    input wire logic [31:0] addr,
    input wire logic [31:0] wdata,
    input wire logic [31:0] rdata,
    input wire logic data_ok,
    input wire logic stall,
    input wire logic [31:0] araddr,
    input wire logic [7:0] arlen,
    input wire logic arvalid,
    input wire logic arready,
    input wire logic rready,
    input wire logic [31:0] awaddr,
    input wire logic [7:0] awlen,
    input wire logic awvalid,
    input wire logic awready,
    input wire logic [31:0] wdata_m,
    input wire logic [3:0] wstrb,
    input wire logic wlast,
    input wire logic wvalid,
    input wire logic wready,
    input wire logic bvalid,
    input wire logic [31:0] exp_rdata,
    input wire logic exp_fill,
    input wire logic exp_wb,
    output int value_errs,
    output int other_errs,
    output int pending
);

    typedef struct packed {
        logic wr;
        logic [31:0] addr;
        logic [31:0] exp;
        logic fill;
        logic wb;
        logic [31:0] cyc;
    } pend_t;

    pend_t q[$];
    logic [31:0] shadow [logic [31:0]];
    logic [31:0] cyc, wb_base;
    int fills, wbs, wb_beats;
    logic wb_open, rst_q;

    function automatic logic [31:0] shadow_word(input logic [31:0] a);
        if (shadow.exists(a)) return shadow[a];
        return a ^ init_key;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            value_errs++;
            $display("ERR %s got 0x%08h expected 0x%08h", name, got, want);
        end
    endtask

    task automatic report_fault(input string what);
        other_errs++;
        $display("%s", what);
    endtask

    // sample mid-cycle when everything has settled
    always @(negedge clk) begin
        pend_t p;
        logic [31:0] mask;
        logic [31:0] waddr;
        if (rst) begin
            q.delete();
            value_errs = 0;
            other_errs = 0;
            fills = 0;
            wbs = 0;
            wb_open = 1'b0;
            cyc = 0;
        end else begin
            cyc++;
            if (rst_q) begin
                check_value("stall", stall, 32'h0);
                check_value("data_ok", data_ok, 32'h0);
                check_value("arvalid", arvalid, 32'h0);
                check_value("rready", rready, 32'h0);
                check_value("awvalid", awvalid, 32'h0);
                check_value("wvalid", wvalid, 32'h0);
                check_value("wlast", wlast, 32'h0);
            end
            if (data_ok) begin
                if (q.size() == 0) begin
                    report_fault("data_ok pulsed with no request outstanding");
                end else begin
                    p = q.pop_front();
                    if (!p.wr) begin
                        check_value("rdata", rdata, shadow_word(p.addr));
                        check_value("rdata (table)", rdata, p.exp);
                    end
                    if (fills != int'(p.fill) || wbs != int'(p.wb)) begin
                        report_fault($sformatf("request at 0x%08h saw %0d fills and %0d write-backs",
                            p.addr, fills, wbs));
                    end
                    if (!p.fill && cyc - p.cyc != 1) begin
                        report_fault($sformatf("hit at 0x%08h answered %0d cycles after acceptance",
                            p.addr, cyc - p.cyc));
                    end
                    fills = 0;
                    wbs = 0;
                end
            end
            if (req && !stall) begin
                waddr = addr & ~32'h3;
                p.wr = wr;
                p.addr = waddr;
                p.exp = exp_rdata;
                p.fill = exp_fill;
                p.wb = exp_wb;
                p.cyc = cyc;
                q.push_back(p);
                if (wr) begin
                    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
                    shadow[waddr] = (shadow_word(waddr) & ~mask) | (wdata & mask);
                end
            end
            if (arvalid && arready) begin
                fills++;
                if (wb_open) report_fault("read burst started before the write-back finished");
                if (q.size() != 0) check_value("araddr", araddr, q[0].addr & ~32'h1f);
                check_value("arlen", arlen, 32'h7);
            end
            if (awvalid && awready) begin
                wbs++;
                wb_open = 1'b1;
                wb_base = awaddr;
                wb_beats = 0;
                check_value("awlen", awlen, 32'h7);
            end
            // victim data must match the line as the core last wrote it
            if (wvalid && wready) begin
                check_value("wdata_m", wdata_m, shadow_word(wb_base + 32'(4 * wb_beats)));
                check_value("wstrb", wstrb, 32'hf);
                check_value("wlast", wlast, 32'(wb_beats == 7));
                wb_beats++;
            end
            if (bvalid) begin
                if (wb_beats != 8) report_fault($sformatf("write burst had %0d beats", wb_beats));
                wb_open = 1'b0;
            end
        end
        rst_q = rst;
        pending = q.size();
    end

endmodule

`default_nettype wire

//--- hdl/dcache_top.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_top import dcache_pkg::*; (
    input wire logic clk,
    input wire logic rst,
    // core side
    input wire logic req,
    input wire logic wr,
    input wire logic [3:0] be,
    input wire logic [31:0] addr,
    input wire logic [31:0] wdata,
    output wire logic [31:0] rdata,
    output wire logic data_ok,
    output wire logic stall,
    // memory side
    output wire logic [31:0] araddr,
    output wire logic [7:0] arlen,
    output wire logic arvalid,
    input wire logic arready,
    input wire logic [31:0] rdata_m,
    input wire logic rlast,
    input wire logic rvalid,
    output wire logic rready,
    output wire logic [31:0] awaddr,
    output wire logic [7:0] awlen,
    output wire logic awvalid,
    input wire logic awready,
    output wire logic [31:0] wdata_m,
    output wire logic [3:0] wstrb,
    output wire logic wlast,
    output wire logic wvalid,
    input wire logic wready,
    input wire logic bvalid
);

    way_state_t [nr_ways-1:0] way_state;
    logic [nr_ways-1:0][31:0] way_word;
    cache_addr_t rd_addr;
    logic [index_bits-1:0] wr_index;
    logic [tag_bits-1:0] wr_tag;
    word_sel_t wr_sel;
    logic [31:0] wr_word;
    logic [3:0] word_we;
    logic lru_victim, rd_en, wr_way, tag_we, set_dirty, clr_dirty, lru_touch;

    line_xfer_if xfer ();

    cache_arrays u_arrays (.*);

    miss_ctrl u_ctrl (.*);

    axi_burst_engine u_engine (.*);

endmodule

`default_nettype wire

//--- hdl/axi_burst_engine.sv
`timescale 1ns/1ns
`default_nettype none

module axi_burst_engine import dcache_pkg::*; (
    input wire logic clk,
    input wire logic rst,
    output logic [31:0] araddr,
    output logic [7:0] arlen,
    output logic arvalid,
    input wire logic arready,
    input wire logic [31:0] rdata_m,
    input wire logic rlast,
    input wire logic rvalid,
    output logic rready,
    output logic [31:0] awaddr,
    output logic [7:0] awlen,
    output logic awvalid,
    input wire logic awready,
    output logic [31:0] wdata_m,
    output logic [3:0] wstrb,
    output logic wlast,
    output logic wvalid,
    input wire logic wready,
    input wire logic bvalid,
    line_xfer_if.engine xfer
);

    localparam logic [2:0] st_idle = 3'd0;
    localparam logic [2:0] st_aw = 3'd1;
    localparam logic [2:0] st_w = 3'd2;
    localparam logic [2:0] st_b = 3'd3;
    localparam logic [2:0] st_ar = 3'd4;
    localparam logic [2:0] st_r = 3'd5;

    logic [2:0] state;
    word_sel_t beat;
    logic w_fire, r_fire;

    assign w_fire = wvalid && wready;
    assign r_fire = rvalid && rready;

    assign arlen = 8'(words_per_line - 1);
    assign awlen = 8'(words_per_line - 1);
    assign wstrb = 4'hf;
    assign wdata_m = xfer.wb_word;

    // look one beat ahead so the array read lines up with wdata
    assign xfer.wb_sel = (state == st_w && w_fire) ? beat + 3'd1 : beat;
    assign xfer.fill_valid = state == st_r && r_fire;
    assign xfer.fill_sel = beat;
    assign xfer.fill_word = rdata_m;
    assign xfer.done = (state == st_r && r_fire && rlast) || (state == st_b && bvalid);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            beat <= '0;
            awvalid <= 1'b0;
            wvalid <= 1'b0;
            wlast <= 1'b0;
            arvalid <= 1'b0;
            rready <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    beat <= '0;
                    if (xfer.start_wb) begin
                        awvalid <= 1'b1;
                        state <= st_aw;
                    end else if (xfer.start_fill) begin
                        arvalid <= 1'b1;
                        state <= st_ar;
                    end
                end
                st_aw: if (awready) begin
                    awvalid <= 1'b0;
                    wvalid <= 1'b1;
                    state <= st_w;
                end
                st_w: if (w_fire) begin
                    beat <= beat + 3'd1;
                    wlast <= beat == word_sel_t'(words_per_line - 2);
                    if (wlast) begin
                        wvalid <= 1'b0;
                        state <= st_b;
                    end
                end
                // write response always accepted
                st_b: if (bvalid) state <= st_idle;
                st_ar: if (arready) begin
                    arvalid <= 1'b0;
                    rready <= 1'b1;
                    state <= st_r;
                end
                st_r: if (r_fire) begin
                    beat <= beat + 3'd1;
                    if (rlast) begin
                        rready <= 1'b0;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && xfer.start_wb) awaddr <= {xfer.wb_line, {offset_bits{1'b0}}};
        if (state == st_idle && xfer.start_fill) araddr <= {xfer.fill_line, {offset_bits{1'b0}}};
    end

    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid);

    a_one_addr_channel: assert property (@(posedge clk) disable iff (rst)
        !(awvalid && arvalid));

endmodule

`default_nettype wire

//--- hdl/miss_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module miss_ctrl import dcache_pkg::*; (
    input wire logic clk,
    input wire logic rst,
    input wire logic req,
    input wire logic wr,
    input wire logic [3:0] be,
    input wire logic [31:0] addr,
    input wire logic [31:0] wdata,
    output logic [31:0] rdata,
    output logic data_ok,
    output logic stall,
    input wire way_state_t [nr_ways-1:0] way_state,
    input wire logic [nr_ways-1:0][31:0] way_word,
    input wire logic lru_victim,
    output logic rd_en,
    output cache_addr_t rd_addr,
    output logic wr_way,
    output logic [3:0] word_we,
    output logic [index_bits-1:0] wr_index,
    output word_sel_t wr_sel,
    output logic [31:0] wr_word,
    output logic tag_we,
    output logic [tag_bits-1:0] wr_tag,
    output logic set_dirty,
    output logic clr_dirty,
    output logic lru_touch,
    line_xfer_if.master xfer
);

    localparam logic [2:0] s_idle = 3'd0;
    localparam logic [2:0] s_wb = 3'd1;
    localparam logic [2:0] s_fstart = 3'd2;
    localparam logic [2:0] s_fill = 3'd3;
    localparam logic [2:0] s_resp = 3'd4;

    logic [2:0] state;
    logic req_q, wr_q, victim_q;
    logic [3:0] be_q;
    cache_addr_t addr_q;
    logic [31:0] wdata_q, resp_word, byte_mask, fill_merged;
    logic [nr_ways-1:0] hit_vec;
    logic hit, hit_way, lookup, miss, victim_dirty, store_hit, fill_beat, fill_hit_word;

    always_comb begin
        for (int w = 0; w < nr_ways; w++) begin
            hit_vec[w] = way_state[w].valid && way_state[w].tag == addr_q.f.tag;
        end
    end

    assign hit = |hit_vec;
    assign hit_way = hit_vec[1];
    assign lookup = state == s_idle && req_q;
    assign miss = lookup && !hit;
    assign store_hit = lookup && hit && wr_q;
    assign victim_dirty = way_state[lru_victim].valid && way_state[lru_victim].dirty;

    assign stall = miss || state == s_wb || state == s_fstart || state == s_fill;
    assign data_ok = (lookup && hit) || state == s_resp;
    assign rdata = (state == s_resp) ? resp_word : way_word[hit_way];

    // refill word with the pending store's bytes on top
    assign fill_beat = state == s_fill && xfer.fill_valid;
    assign fill_hit_word = xfer.fill_sel == addr_q.f.word_sel;
    assign byte_mask = {{8{be_q[3]}}, {8{be_q[2]}}, {8{be_q[1]}}, {8{be_q[0]}}};
    assign fill_merged = (wr_q && fill_hit_word) ?
        (xfer.fill_word & ~byte_mask) | (wdata_q & byte_mask) : xfer.fill_word;

    assign xfer.start_wb = miss && victim_dirty;
    assign xfer.start_fill = (miss && !victim_dirty) || state == s_fstart;
    assign xfer.wb_line = {way_state[lru_victim].tag, addr_q.f.index};
    assign xfer.fill_line = {addr_q.f.tag, addr_q.f.index};
    assign xfer.wb_word = way_word[victim_q];

    // during write-back the engine walks the victim line
    always_comb begin
        rd_addr.raw = addr;
        rd_en = req && !stall;
        if (state == s_wb) begin
            rd_addr = addr_q;
            rd_addr.f.word_sel = xfer.wb_sel;
            rd_en = 1'b1;
        end
    end

    assign wr_way = (state == s_fill) ? victim_q : hit_way;
    assign word_we = fill_beat ? 4'hf : (store_hit ? be_q : 4'h0);
    assign wr_index = addr_q.f.index;
    assign wr_sel = fill_beat ? xfer.fill_sel : addr_q.f.word_sel;
    assign wr_word = fill_beat ? fill_merged : wdata_q;
    assign tag_we = fill_beat;
    assign wr_tag = addr_q.f.tag;
    assign set_dirty = store_hit || (fill_beat && wr_q);
    assign clr_dirty = fill_beat && !wr_q;
    assign lru_touch = (lookup && hit) || (state == s_fill && xfer.done);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_idle;
            req_q <= 1'b0;
        end else begin
            if (!stall) req_q <= req;
            case (state)
                s_idle: if (miss) state <= victim_dirty ? s_wb : s_fill;
                s_wb: if (xfer.done) state <= s_fstart;
                s_fstart: state <= s_fill;
                s_fill: if (xfer.done) state <= s_resp;
                s_resp: state <= s_idle;
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req && !stall) begin
            wr_q <= wr;
            be_q <= be;
            addr_q.raw <= addr;
            wdata_q <= wdata;
        end
        if (miss) victim_q <= lru_victim;
        if (fill_beat && fill_hit_word) resp_word <= fill_merged;
    end

    a_ok_not_stalled: assert property (@(posedge clk) disable iff (rst) !(stall && data_ok));

    a_fill_after_wb: assert property (@(posedge clk) disable iff (rst)
        xfer.start_wb |=> (!xfer.start_fill until_with xfer.done));

endmodule

`default_nettype wire

//--- hdl/cache_arrays.sv
`timescale 1ns/1ns
`default_nettype none

module cache_arrays import dcache_pkg::*; (
    input wire logic clk,
    input wire logic rst,
    input wire logic rd_en,
    input wire cache_addr_t rd_addr,
    input wire logic wr_way,
    input wire logic [3:0] word_we,
    input wire logic [index_bits-1:0] wr_index,
    input wire word_sel_t wr_sel,
    input wire logic [31:0] wr_word,
    input wire logic tag_we,
    input wire logic [tag_bits-1:0] wr_tag,
    input wire logic set_dirty,
    input wire logic clr_dirty,
    input wire logic lru_touch,
    output way_state_t [nr_ways-1:0] way_state,
    output logic [nr_ways-1:0][31:0] way_word,
    output logic lru_victim
);

    localparam int nr_sets = 2 ** index_bits;
    localparam int data_depth = nr_sets * words_per_line;

    logic [nr_sets-1:0][nr_ways-1:0] valid_q;
    logic [nr_sets-1:0][nr_ways-1:0] dirty_q;
    logic [nr_sets-1:0] lru_q;
    logic [index_bits-1:0] idx_q;
    logic fwd_way;
    logic [3:0] fwd_be;
    logic [31:0] fwd_word;

    // state bits live in flops so a lookup always sees the latest update
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q <= '0;
        end else begin
            if (tag_we) valid_q[wr_index][wr_way] <= 1'b1;
            if (set_dirty) dirty_q[wr_index][wr_way] <= 1'b1;
            else if (clr_dirty) dirty_q[wr_index][wr_way] <= 1'b0;
            // point at the other way
            if (lru_touch) lru_q[wr_index] <= ~wr_way;
        end
    end

    // catch a store landing on the word being read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            idx_q <= rd_addr.f.index;
            fwd_way <= wr_way;
            fwd_word <= wr_word;
            if (wr_index == rd_addr.f.index && wr_sel == rd_addr.f.word_sel) fwd_be <= word_we;
            else fwd_be <= 4'h0;
        end
    end

    assign lru_victim = lru_q[idx_q];

    for (genvar w = 0; w < nr_ways; w++) begin : g_way
        logic [31:0] data_mem [data_depth];
        logic [tag_bits-1:0] tag_mem [nr_sets];
        logic [31:0] rd_word;
        logic [tag_bits-1:0] rd_tag;
        logic [31:0] fwd_mask;

        always_ff @(posedge clk) begin
            for (int b = 0; b < 4; b++) begin
                if (word_we[b] && wr_way == w) begin
                    data_mem[{wr_index, wr_sel}][8*b +: 8] <= wr_word[8*b +: 8];
                end
            end
            if (tag_we && wr_way == w) tag_mem[wr_index] <= wr_tag;
            if (rd_en) begin
                rd_word <= data_mem[{rd_addr.f.index, rd_addr.f.word_sel}];
                rd_tag <= tag_mem[rd_addr.f.index];
            end
        end

        assign fwd_mask = (fwd_way == w) ?
            {{8{fwd_be[3]}}, {8{fwd_be[2]}}, {8{fwd_be[1]}}, {8{fwd_be[0]}}} : '0;
        assign way_word[w] = (rd_word & ~fwd_mask) | (fwd_word & fwd_mask);
        assign way_state[w] = {valid_q[idx_q][w], dirty_q[idx_q][w], rd_tag};
    end

    // a store without a tag write lands in a line that is already valid
    a_write_valid_line: assert property (@(posedge clk) disable iff (rst)
        (|word_we && !tag_we) |-> valid_q[wr_index][wr_way]);

endmodule

`default_nettype wire

//--- hdl/line_xfer_if.sv
`timescale 1ns/1ns
`default_nettype none

interface line_xfer_if import dcache_pkg::*; ();

    // requests from miss_ctrl
    logic start_wb;
    logic start_fill;
    line_addr_t wb_line;
    line_addr_t fill_line;
    logic [31:0] wb_word;

    // answers from the burst engine
    word_sel_t wb_sel;
    logic fill_valid;
    word_sel_t fill_sel;
    logic [31:0] fill_word;
    logic done;

    modport master (
        output start_wb, start_fill, wb_line, fill_line, wb_word,
        input wb_sel, fill_valid, fill_sel, fill_word, done
    );

    modport engine (
        input start_wb, start_fill, wb_line, fill_line, wb_word,
        output wb_sel, fill_valid, fill_sel, fill_word, done
    );

endinterface

`default_nettype wire

//--- hdl/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // 32-byte lines, 128 sets and 2 ways
    localparam int tag_bits = 20;
    localparam int index_bits = 7;
    localparam int offset_bits = 5;
    localparam int words_per_line = 8;
    localparam int nr_ways = 2;

    typedef logic [offset_bits-3:0] word_sel_t;

    // tag and index only
    typedef logic [tag_bits+index_bits-1:0] line_addr_t;

    typedef struct packed {
        logic [tag_bits-1:0] tag;
        logic [index_bits-1:0] index;
        word_sel_t word_sel;
        logic [1:0] byte_sel;
    } addr_fields_t;

    // core address seen as a word or as fields
    typedef union packed {
        logic [31:0] raw;
        addr_fields_t f;
    } cache_addr_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        logic [tag_bits-1:0] tag;
    } way_state_t;

endpackage

`default_nettype wire
